//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_riscv_data_cache
FILELIST := files.f
BUILD    := obj_dir

BIN  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

//--- common/riscv_dcache_pkg.sv
`default_nettype none

package riscv_dcache_pkg;

  localparam int LINE_BYTES = 16;   // fixed, 128-bit line and bit-3 dword select
  localparam int OFFSET_W   = $clog2(LINE_BYTES);

  typedef logic [63:0]           dword_t;
  typedef logic [127:0]          line_t;
  typedef logic [63:0]           paddr_t;
  typedef logic [63-OFFSET_W:0]  line_addr_t;   // paddr without byte offset

  // store size, same as the low funct3 bits of a store
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'b00,
    SIZE_HALF   = 2'b01,
    SIZE_WORD   = 2'b10,
    SIZE_DOUBLE = 2'b11
  } store_size_t;

  // bit 5 = doubleword, bits 4:0 = funct5
  typedef logic [5:0] amo_op_t;

  localparam logic [4:0] AMO_ADD  = 5'b00000;
  localparam logic [4:0] AMO_SWAP = 5'b00001;
  localparam logic [4:0] AMO_XOR  = 5'b00100;
  localparam logic [4:0] AMO_OR   = 5'b01000;
  localparam logic [4:0] AMO_AND  = 5'b01100;
  localparam logic [4:0] AMO_MIN  = 5'b10000;
  localparam logic [4:0] AMO_MAX  = 5'b10100;
  localparam logic [4:0] AMO_MINU = 5'b11000;
  localparam logic [4:0] AMO_MAXU = 5'b11100;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE_BACK,
    S_REFILL,
    S_AMO_READ,
    S_AMO_WRITE
  } dcache_state_t;

  // request toward main memory
  typedef struct packed {
    logic       rden;
    logic       wren;
    line_addr_t line_addr;
    line_t      wline;
  } mem_req_t;

endpackage

`default_nettype wire

//--- files.f
common/riscv_dcache_pkg.sv
hw/riscv_dcache/riscv_amo_unit.sv
hw/riscv_dcache/riscv_dcache_tag.sv
hw/riscv_dcache/riscv_dcache_data.sv
hw/riscv_dcache/riscv_dcache_fsm.sv
hw/dram.sv
hw/riscv_dcache/riscv_data_cache.sv
verif/tb_riscv_data_cache.sv

//--- hw/dram.sv
`timescale 1ns/1ns
`default_nettype none

module dram #(
  parameter  int MEM_DEPTH   = 1024,
  parameter  int MEM_LATENCY = 4,
  localparam int MEM_AW      = $clog2(MEM_DEPTH),
  localparam int CNT_W       = $clog2(MEM_LATENCY + 1)
) (
  input  logic                       i_riscv_dcache_clk,
  input  logic                       i_riscv_dcache_rst,
  input  riscv_dcache_pkg::mem_req_t i_mem_req,
  output riscv_dcache_pkg::line_t    o_mem_line,
  output logic                       o_mem_ready
);
  import riscv_dcache_pkg::*;

  line_t             mem [MEM_DEPTH];
  logic [CNT_W-1:0]  cnt_q;   // cycles since the strobe rose
  logic              strobe;
  logic [MEM_AW-1:0] addr;

  assign strobe      = i_mem_req.rden | i_mem_req.wren;
  assign addr        = i_mem_req.line_addr[MEM_AW-1:0];
  assign o_mem_ready = strobe && (cnt_q == CNT_W'(MEM_LATENCY));
  assign o_mem_line  = mem[addr];

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++)
      mem[i] = '0;
  end

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst)
      cnt_q <= '0;
    else if (o_mem_ready || !strobe)
      cnt_q <= '0;   // next strobe starts a fresh count
    else
      cnt_q <= cnt_q + 1'b1;
  end

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (o_mem_ready && i_mem_req.wren)
      mem[addr] <= i_mem_req.wline;
  end

  a_req_stable: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_riscv_dcache_rst)
    (strobe && !o_mem_ready) |=> $stable(i_mem_req)
  );

endmodule

`default_nettype wire

//--- hw/riscv_dcache/riscv_amo_unit.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_amo_unit (
  input  riscv_dcache_pkg::amo_op_t i_riscv_amo_ctrl,
  input  riscv_dcache_pkg::dword_t  i_riscv_amo_rs1data,
  input  riscv_dcache_pkg::dword_t  i_riscv_amo_rs2data,
  output riscv_dcache_pkg::dword_t  o_riscv_amo_result
);
  import riscv_dcache_pkg::*;

  logic       is_dword;
  logic [4:0] funct5;
  logic       lt_s;   // rs1 < rs2 signed
  logic       lt_u;   // rs1 < rs2 unsigned
  dword_t     sum;
  dword_t     res;

  assign is_dword = i_riscv_amo_ctrl[5];
  assign funct5   = i_riscv_amo_ctrl[4:0];

  always_comb begin
    if (is_dword) begin
      lt_s = $signed(i_riscv_amo_rs1data) < $signed(i_riscv_amo_rs2data);
      lt_u = i_riscv_amo_rs1data < i_riscv_amo_rs2data;
      sum  = i_riscv_amo_rs1data + i_riscv_amo_rs2data;
    end else begin   // word op on the low halves
      lt_s = $signed(i_riscv_amo_rs1data[31:0]) < $signed(i_riscv_amo_rs2data[31:0]);
      lt_u = i_riscv_amo_rs1data[31:0] < i_riscv_amo_rs2data[31:0];
      sum  = {32'b0, i_riscv_amo_rs1data[31:0] + i_riscv_amo_rs2data[31:0]};
    end
  end

  always_comb begin
    case (funct5)
      AMO_SWAP: res = i_riscv_amo_rs2data;
      AMO_ADD:  res = sum;
      AMO_XOR:  res = i_riscv_amo_rs1data ^ i_riscv_amo_rs2data;
      AMO_AND:  res = i_riscv_amo_rs1data & i_riscv_amo_rs2data;
      AMO_OR:   res = i_riscv_amo_rs1data | i_riscv_amo_rs2data;
      AMO_MIN:  res = lt_s ? i_riscv_amo_rs1data : i_riscv_amo_rs2data;
      AMO_MAX:  res = lt_s ? i_riscv_amo_rs2data : i_riscv_amo_rs1data;
      AMO_MINU: res = lt_u ? i_riscv_amo_rs1data : i_riscv_amo_rs2data;
      AMO_MAXU: res = lt_u ? i_riscv_amo_rs2data : i_riscv_amo_rs1data;
      default:  res = i_riscv_amo_rs1data;   // unknown op keeps memory
    endcase
  end

  // word result sits in the low half
  assign o_riscv_amo_result = is_dword ? res : {32'b0, res[31:0]};

endmodule

`default_nettype wire

//--- hw/riscv_dcache/riscv_data_cache.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_data_cache #(
  parameter int CACHE_DEPTH = 64,
  parameter int MEM_DEPTH   = 1024,
  parameter int MEM_LATENCY = 4
) (
  input  logic                           i_riscv_dcache_clk,
  input  logic                           i_riscv_dcache_rst,
  input  logic                           i_riscv_dcache_globstall,
  input  logic                           i_riscv_dcache_cpu_wren,
  input  logic                           i_riscv_dcache_cpu_rden,
  input  riscv_dcache_pkg::store_size_t  i_riscv_dcache_store_src,
  input  riscv_dcache_pkg::amo_op_t      i_riscv_dcache_amo_op,
  input  logic                           i_riscv_dcache_amo,
  input  riscv_dcache_pkg::paddr_t       i_riscv_dcache_phys_addr,
  input  riscv_dcache_pkg::dword_t       i_riscv_dcache_cpu_data_in,
  output riscv_dcache_pkg::dword_t       o_riscv_dcache_cpu_data_out,
  output logic                           o_riscv_dcache_cpu_stall
);
  import riscv_dcache_pkg::*;

  localparam int INDEX = $clog2(CACHE_DEPTH);
  localparam int TAG   = 64 - OFFSET_W - INDEX;

  logic [TAG-1:0]      addr_tag;
  logic [INDEX-1:0]    addr_index;
  logic [OFFSET_W-1:0] addr_offset;

  logic fsm_cache_wren, fsm_refill, fsm_amo_sel;
  logic fsm_mem_rden, fsm_mem_wren;
  logic fsm_set_dirty, fsm_set_valid, fsm_old_tag_sel;
  logic fsm_amo_buffer_en;

  logic           tag_hit, tag_dirty;
  logic [TAG-1:0] tag_old;

  line_t       cache_line_in, cache_line_out;
  store_size_t cache_size;
  dword_t      dword_sel;
  dword_t      amo_buffer;   // rs1 operand of the AMO
  dword_t      amo_result;
  mem_req_t    mem_req;
  line_t       mem_line;
  logic        mem_ready;

  assign {addr_tag, addr_index, addr_offset} = i_riscv_dcache_phys_addr;

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////
  assign dword_sel = addr_offset[3] ? cache_line_out[127:64] : cache_line_out[63:0];
  assign o_riscv_dcache_cpu_data_out = dword_sel;

  // amo write uses word or double from op bit 5
  assign cache_size = fsm_amo_sel ? (i_riscv_dcache_amo_op[5] ? SIZE_DOUBLE : SIZE_WORD)
                                  : i_riscv_dcache_store_src;

  always_comb begin
    if (fsm_refill)
      cache_line_in = mem_line;
    else if (fsm_amo_sel)
      cache_line_in = {64'b0, amo_result};
    else
      cache_line_in = {64'b0, i_riscv_dcache_cpu_data_in};
  end

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst) begin
      amo_buffer <= '0;
    end else if (fsm_amo_buffer_en) begin
      if (i_riscv_dcache_amo_op[5])
        amo_buffer <= dword_sel;
      else   // word op, old word moved to the low half
        amo_buffer <= {32'b0, addr_offset[2] ? dword_sel[63:32] : dword_sel[31:0]};
    end
  end

  assign mem_req.rden      = fsm_mem_rden;
  assign mem_req.wren      = fsm_mem_wren;
  assign mem_req.line_addr = fsm_old_tag_sel ? {tag_old, addr_index} : {addr_tag, addr_index};
  assign mem_req.wline     = cache_line_out;   // victim line on write-back

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////
  riscv_dcache_tag #(.CACHE_DEPTH(CACHE_DEPTH)) u_dcache_tag (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_tag_index        (addr_index),
    .i_tag_tag          (addr_tag),
    .i_tag_set_dirty    (fsm_set_dirty),
    .i_tag_set_valid    (fsm_set_valid),
    .i_tag_replace      (fsm_refill & fsm_set_valid),
    .o_tag_hit          (tag_hit),
    .o_tag_dirty        (tag_dirty),
    .o_tag_old          (tag_old)
  );

  riscv_dcache_data #(.CACHE_DEPTH(CACHE_DEPTH)) u_dcache_data (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_data_wren        (fsm_cache_wren),
    .i_data_index       (addr_index),
    .i_data_offset      (addr_offset),
    .i_data_size        (cache_size),
    .i_data_refill      (fsm_refill),
    .i_data_line        (cache_line_in),
    .o_data_line        (cache_line_out)
  );

  riscv_dcache_fsm u_dcache_fsm (
    .i_riscv_dcache_clk  (i_riscv_dcache_clk),
    .i_riscv_dcache_rst  (i_riscv_dcache_rst),
    .i_fsm_globstall     (i_riscv_dcache_globstall),
    .i_fsm_rden          (i_riscv_dcache_cpu_rden),
    .i_fsm_wren          (i_riscv_dcache_cpu_wren),
    .i_fsm_amo           (i_riscv_dcache_amo),
    .i_fsm_hit           (tag_hit),
    .i_fsm_dirty         (tag_dirty),
    .i_fsm_mem_ready     (mem_ready),
    .o_fsm_cache_wren    (fsm_cache_wren),
    .o_fsm_refill        (fsm_refill),
    .o_fsm_amo_sel       (fsm_amo_sel),
    .o_fsm_mem_rden      (fsm_mem_rden),
    .o_fsm_mem_wren      (fsm_mem_wren),
    .o_fsm_set_dirty     (fsm_set_dirty),
    .o_fsm_set_valid     (fsm_set_valid),
    .o_fsm_old_tag_sel   (fsm_old_tag_sel),
    .o_fsm_amo_buffer_en (fsm_amo_buffer_en),
    .o_fsm_stall         (o_riscv_dcache_cpu_stall)
  );

  riscv_amo_unit u_riscv_amo_unit (
    .i_riscv_amo_ctrl    (i_riscv_dcache_amo_op),
    .i_riscv_amo_rs1data (amo_buffer),
    .i_riscv_amo_rs2data (i_riscv_dcache_cpu_data_in),
    .o_riscv_amo_result  (amo_result)
  );

  dram #(
    .MEM_DEPTH   (MEM_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_mem_req          (mem_req),
    .o_mem_line         (mem_line),
    .o_mem_ready        (mem_ready)
  );

endmodule

`default_nettype wire

//--- hw/riscv_dcache/riscv_dcache_data.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_dcache_data #(
  parameter  int CACHE_DEPTH = 64,
  localparam int INDEX       = $clog2(CACHE_DEPTH)
) (
  input  logic                          i_riscv_dcache_clk,
  input  logic                          i_data_wren,
  input  logic [INDEX-1:0]              i_data_index,
  input  logic [3:0]                    i_data_offset,
  input  riscv_dcache_pkg::store_size_t i_data_size,
  input  logic                          i_data_refill,
  input  riscv_dcache_pkg::line_t       i_data_line,
  output riscv_dcache_pkg::line_t       o_data_line
);
  import riscv_dcache_pkg::*;

  line_t                 line_mem [CACHE_DEPTH];
  line_t                 wr_line;
  logic [LINE_BYTES-1:0] size_mask;
  logic [LINE_BYTES-1:0] byte_en;

  ////////////////////////////////////////
  // byte lane selection
  ////////////////////////////////////////
  always_comb begin
    case (i_data_size)
      SIZE_BYTE: size_mask = 16'h0001;
      SIZE_HALF: size_mask = 16'h0003;
      SIZE_WORD: size_mask = 16'h000f;
      default:   size_mask = 16'h00ff;
    endcase
  end

  always_comb begin
    if (i_data_refill) begin
      wr_line = i_data_line;   // whole line from memory
      byte_en = '1;
    end else begin
      wr_line = i_data_line << {i_data_offset, 3'b000};
      byte_en = size_mask << i_data_offset;   // aligned, never wraps
    end
  end

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_data_wren) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (byte_en[b])
          line_mem[i_data_index][b*8 +: 8] <= wr_line[b*8 +: 8];
      end
    end
  end

  assign o_data_line = line_mem[i_data_index];   // async read

endmodule

`default_nettype wire

//--- hw/riscv_dcache/riscv_dcache_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_dcache_fsm (
  input  logic i_riscv_dcache_clk,
  input  logic i_riscv_dcache_rst,
  input  logic i_fsm_globstall,
  input  logic i_fsm_rden,
  input  logic i_fsm_wren,
  input  logic i_fsm_amo,
  input  logic i_fsm_hit,
  input  logic i_fsm_dirty,
  input  logic i_fsm_mem_ready,
  output logic o_fsm_cache_wren,
  output logic o_fsm_refill,
  output logic o_fsm_amo_sel,
  output logic o_fsm_mem_rden,
  output logic o_fsm_mem_wren,
  output logic o_fsm_set_dirty,
  output logic o_fsm_set_valid,
  output logic o_fsm_old_tag_sel,
  output logic o_fsm_amo_buffer_en,
  output logic o_fsm_stall
);
  import riscv_dcache_pkg::*;

  dcache_state_t state_q, state_d;
  logic          amo_done_q;   // amo written, let the final hit pass
  logic          access;

  assign access = i_fsm_rden | i_fsm_wren | i_fsm_amo;

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst) begin
      state_q    <= S_IDLE;
      amo_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == S_AMO_WRITE)
        amo_done_q <= 1'b1;
      else if (state_q == S_IDLE && !i_fsm_globstall)
        amo_done_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb begin
    state_d             = state_q;
    o_fsm_cache_wren    = 1'b0;
    o_fsm_refill        = 1'b0;
    o_fsm_amo_sel       = 1'b0;
    o_fsm_mem_rden      = 1'b0;
    o_fsm_mem_wren      = 1'b0;
    o_fsm_set_dirty     = 1'b0;
    o_fsm_set_valid     = 1'b0;
    o_fsm_old_tag_sel   = 1'b0;
    o_fsm_amo_buffer_en = 1'b0;
    o_fsm_stall         = 1'b0;

    case (state_q)
      S_IDLE: begin
        if (access && !i_fsm_globstall) begin
          if (!i_fsm_hit) begin
            o_fsm_stall = 1'b1;   // miss, stall from the request cycle
            state_d     = i_fsm_dirty ? S_WRITE_BACK : S_REFILL;
          end else if (i_fsm_amo && !amo_done_q) begin
            o_fsm_stall = 1'b1;
            state_d     = S_AMO_READ;
          end else if (i_fsm_wren && !i_fsm_amo) begin
            o_fsm_cache_wren = 1'b1;   // store hit
            o_fsm_set_dirty  = 1'b1;
          end
        end
      end
      S_WRITE_BACK: begin
        o_fsm_stall       = 1'b1;
        o_fsm_mem_wren    = 1'b1;
        o_fsm_old_tag_sel = 1'b1;
        if (i_fsm_mem_ready)
          state_d = S_REFILL;
      end
      S_REFILL: begin
        o_fsm_stall    = 1'b1;
        o_fsm_mem_rden = 1'b1;
        o_fsm_refill   = 1'b1;
        if (i_fsm_mem_ready) begin   // line valid in the ready cycle
          o_fsm_cache_wren = 1'b1;
          o_fsm_set_valid  = 1'b1;
          state_d          = S_IDLE;
        end
      end
      S_AMO_READ: begin
        o_fsm_stall         = 1'b1;
        o_fsm_amo_buffer_en = 1'b1;
        state_d             = S_AMO_WRITE;
      end
      S_AMO_WRITE: begin
        o_fsm_stall      = 1'b1;
        o_fsm_amo_sel    = 1'b1;
        o_fsm_cache_wren = 1'b1;
        o_fsm_set_dirty  = 1'b1;
        state_d          = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  a_strobe_excl: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_riscv_dcache_rst)
    !(o_fsm_mem_rden && o_fsm_mem_wren)
  );

  // cpu never sees a busy cache as done
  a_stall_busy: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_riscv_dcache_rst)
    (state_q != S_IDLE) |-> o_fsm_stall
  );

endmodule

`default_nettype wire

//--- hw/riscv_dcache/riscv_dcache_tag.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_dcache_tag #(
  parameter  int CACHE_DEPTH = 64,
  localparam int INDEX       = $clog2(CACHE_DEPTH),
  localparam int TAG         = 64 - $clog2(riscv_dcache_pkg::LINE_BYTES) - INDEX
) (
  input  logic             i_riscv_dcache_clk,
  input  logic             i_riscv_dcache_rst,
  input  logic [INDEX-1:0] i_tag_index,
  input  logic [TAG-1:0]   i_tag_tag,
  input  logic             i_tag_set_dirty,
  input  logic             i_tag_set_valid,
  input  logic             i_tag_replace,
  output logic             o_tag_hit,
  output logic             o_tag_dirty,
  output logic [TAG-1:0]   o_tag_old
);

  logic [CACHE_DEPTH-1:0] valid_q;
  logic [TAG-1:0]         tag_mem   [CACHE_DEPTH];
  logic                   dirty_mem [CACHE_DEPTH];

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst)
      valid_q <= '0;
    else if (i_tag_set_valid)
      valid_q[i_tag_index] <= 1'b1;
  end

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_tag_replace) begin   // new line comes in clean
      tag_mem[i_tag_index]   <= i_tag_tag;
      dirty_mem[i_tag_index] <= 1'b0;
    end else if (i_tag_set_dirty) begin
      dirty_mem[i_tag_index] <= 1'b1;
    end
  end

  assign o_tag_hit   = valid_q[i_tag_index] && (tag_mem[i_tag_index] == i_tag_tag);
  assign o_tag_dirty = valid_q[i_tag_index] && dirty_mem[i_tag_index];
  assign o_tag_old   = tag_mem[i_tag_index];   // victim tag for write-back

  // a refill and a store never land on the array in one cycle
  a_replace_not_dirty: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_riscv_dcache_rst)
    !(i_tag_replace && i_tag_set_dirty)
  );

endmodule

`default_nettype wire

//--- verif/tb_riscv_data_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_data_cache;
  import riscv_dcache_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        globstall;
  logic        cpu_wren;
  logic        cpu_rden;
  store_size_t store_src;
  amo_op_t     amo_op;
  logic        amo;
  paddr_t      phys_addr;
  dword_t      cpu_data_in;
  dword_t      cpu_data_out;
  logic        cpu_stall;

  logic [31:0] lfsr_q = 32'hbcdd;
  dword_t      ref_mem [paddr_t];   // keyed by doubleword address

  always #4 clk = ~clk;

  riscv_data_cache #(
    .CACHE_DEPTH (64),
    .MEM_DEPTH   (1024),
    .MEM_LATENCY (4)
  ) u_dut (
    .i_riscv_dcache_clk          (clk),
    .i_riscv_dcache_rst          (rst),
    .i_riscv_dcache_globstall    (globstall),
    .i_riscv_dcache_cpu_wren     (cpu_wren),
    .i_riscv_dcache_cpu_rden     (cpu_rden),
    .i_riscv_dcache_store_src    (store_src),
    .i_riscv_dcache_amo_op       (amo_op),
    .i_riscv_dcache_amo          (amo),
    .i_riscv_dcache_phys_addr    (phys_addr),
    .i_riscv_dcache_cpu_data_in  (cpu_data_in),
    .o_riscv_dcache_cpu_data_out (cpu_data_out),
    .o_riscv_dcache_cpu_stall    (cpu_stall)
  );

  ////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////
  // galois lfsr stepped once per bit
  function automatic dword_t rand_bits(input int n);
    dword_t v;
    logic   b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b)
        lfsr_q = lfsr_q ^ 32'h8020_0003;
      v = {v[62:0], b};
    end
    return v;
  endfunction

  function automatic dword_t ref_read(input paddr_t dw_addr);
    if (ref_mem.exists(dw_addr))
      return ref_mem[dw_addr];
    return '0;   // untouched memory reads zero
  endfunction

  // little endian with the low byte of d at a
  task automatic ref_store(input paddr_t a, input store_size_t sz, input dword_t d);
    int     nbytes;
    int     lane;
    paddr_t ba;
    dword_t w;
    nbytes = 1 << int'(sz);
    for (int i = 0; i < nbytes; i++) begin
      ba           = a + paddr_t'(i);
      lane         = int'(ba[2:0]);
      w            = ref_read(ba >> 3);
      w[8*lane +: 8] = d[8*i +: 8];
      ref_mem[ba >> 3] = w;
    end
  endtask

  // word ops compare sign or zero extended low halves
  function automatic dword_t amo_expect(input amo_op_t op, input dword_t a, input dword_t b);
    dword_t sa, sb, ua, ub, r;
    ua = op[5] ? a : {32'b0, a[31:0]};
    ub = op[5] ? b : {32'b0, b[31:0]};
    sa = op[5] ? a : {{32{a[31]}}, a[31:0]};
    sb = op[5] ? b : {{32{b[31]}}, b[31:0]};
    case (op[4:0])
      AMO_SWAP: r = b;
      AMO_ADD:  r = a + b;
      AMO_XOR:  r = a ^ b;
      AMO_AND:  r = a & b;
      AMO_OR:   r = a | b;
      AMO_MIN:  r = ($signed(sa) < $signed(sb)) ? a : b;
      AMO_MAX:  r = ($signed(sa) < $signed(sb)) ? b : a;
      AMO_MINU: r = (ua < ub) ? a : b;
      AMO_MAXU: r = (ua < ub) ? b : a;
      default:  r = a;
    endcase
    return op[5] ? r : {32'b0, r[31:0]};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_dword(input dword_t got, input dword_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_stall(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp));
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////
  // stalls < 0 means the stall count is not checked
  task automatic wait_done(input int stalls);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (stalls >= 0)
        check_stall(cpu_stall, logic'(n < stalls), "stall in access cycle");
      if (!cpu_stall) begin
        done = 1'b1;
      end else begin
        n++;
        if (n >= WAIT_LIMIT)
          abort_run("timeout: cpu stall did not fall within 200 cycles");
      end
    end
  endtask

  task automatic do_load(input paddr_t a, input int stalls, output dword_t d);
    @(posedge clk);
    cpu_rden  <= 1'b1;
    phys_addr <= a;
    wait_done(stalls);
    d = cpu_data_out;
    @(posedge clk);
    cpu_rden <= 1'b0;
  endtask

  task automatic do_store(input paddr_t a, input store_size_t sz, input dword_t d,
                          input int stalls);
    @(posedge clk);
    cpu_wren    <= 1'b1;
    store_src   <= sz;
    phys_addr   <= a;
    cpu_data_in <= d;
    wait_done(stalls);
    @(posedge clk);   // store lands on this edge
    cpu_wren <= 1'b0;
  endtask

  task automatic do_amo(input paddr_t a, input amo_op_t op, input dword_t d, input int stalls);
    @(posedge clk);
    amo         <= 1'b1;
    amo_op      <= op;
    phys_addr   <= a;
    cpu_data_in <= d;
    wait_done(stalls);
    @(posedge clk);
    amo <= 1'b0;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic test_reset_load();
    dword_t got;
    do_load(64'h3f00, -1, got);
    check_dword(got, 64'h0, "fresh load after reset");
  endtask

  task automatic test_store_sizes();
    paddr_t a;
    dword_t d, got;
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 4; k++) begin
        a = rand_bits(14) & ~((64'd1 << s) - 64'd1);
        d = rand_bits(64);
        do_store(a, store_size_t'(s), d, -1);
        ref_store(a, store_size_t'(s), d);
        do_load(a & ~64'h7, 0, got);   // line is resident so this hits
        check_dword(got, ref_read(a >> 3), "load after store");
      end
    end
  endtask

  task automatic test_write_back();
    paddr_t a, b;
    dword_t d, got;
    line_t  mline;
    a = 64'h0200;
    b = 64'h2a00;   // same index with another tag
    d = rand_bits(64);
    do_store(a, SIZE_DOUBLE, d, -1);
    ref_store(a, SIZE_DOUBLE, d);
    d = rand_bits(64);
    do_store(a + 64'hc, SIZE_WORD, d, 0);
    ref_store(a + 64'hc, SIZE_WORD, d);
    do_load(b, -1, got);
    check_dword(got, ref_read(b >> 3), "load of conflicting line");
    mline = u_dut.u_dram.mem[a[13:4]];
    check_dword(mline[63:0], ref_read(a >> 3), "written back low dword");
    check_dword(mline[127:64], ref_read((a >> 3) + 64'd1), "written back high dword");
    do_load(a, -1, got);
    check_dword(got, ref_read(a >> 3), "reload of evicted line");
    do_load(a + 64'h8, 0, got);
    check_dword(got, ref_read((a >> 3) + 64'd1), "reload of evicted line high");
  endtask

  task automatic test_amo_ops();
    logic [4:0] ops [9];
    paddr_t     a;
    amo_op_t    op;
    dword_t     init, opnd, old, exp, got;
    ops = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
    for (int i = 0; i < 9; i++) begin
      for (int dw = 0; dw < 2; dw++) begin
        op = {dw[0], ops[i]};
        a  = rand_bits(14) & ~64'h7;
        if (dw == 0)
          a = a | (rand_bits(1) << 2);
        opnd = rand_bits(64);
        init = rand_bits(64);
        do_store(a & ~64'h7, SIZE_DOUBLE, init, -1);
        ref_store(a & ~64'h7, SIZE_DOUBLE, init);
        do_amo(a, op, opnd, 3);   // request cycle plus amo_read and amo_write
        old = ref_read(a >> 3);
        if (dw == 1) begin
          exp = amo_expect(op, old, opnd);
          ref_store(a, SIZE_DOUBLE, exp);
        end else begin
          exp = amo_expect(op, {32'b0, a[2] ? old[63:32] : old[31:0]}, opnd);
          ref_store(a, SIZE_WORD, exp);
        end
        do_load(a & ~64'h7, 0, got);
        check_dword(got, ref_read(a >> 3), $sformatf("amo op %h result", op));
      end
    end
  endtask

  task automatic test_globstall();
    paddr_t a, b;
    dword_t d1, got;
    line_t  snap, mline;
    a  = 64'h1a30;
    b  = 64'h1230;   // conflicts with a
    d1 = rand_bits(64);
    do_store(a, SIZE_DOUBLE, d1, -1);
    ref_store(a, SIZE_DOUBLE, d1);
    snap = u_dut.u_dram.mem[a[13:4]];
    @(posedge clk);
    globstall   <= 1'b1;
    cpu_wren    <= 1'b1;
    store_src   <= SIZE_DOUBLE;
    phys_addr   <= a;
    cpu_data_in <= ~d1;
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      check_stall(cpu_stall, 1'b0, "stall on held store hit");
    end
    @(posedge clk);
    cpu_wren  <= 1'b0;
    cpu_rden  <= 1'b1;
    phys_addr <= b;
    for (int k = 0; k < 10; k++) begin
      @(negedge clk);
      check_stall(cpu_stall, 1'b0, "stall on held dirty miss");
    end
    mline = u_dut.u_dram.mem[a[13:4]];
    check_dword(mline[63:0], snap[63:0], "memory low dword under global stall");
    check_dword(mline[127:64], snap[127:64], "memory high dword under global stall");
    @(posedge clk);
    globstall <= 1'b0;
    wait_done(-1);
    check_dword(cpu_data_out, ref_read(b >> 3), "load after global stall release");
    @(posedge clk);
    cpu_rden <= 1'b0;
    do_load(a, -1, got);
    check_dword(got, ref_read(a >> 3), "held store must not write");
  endtask

  task automatic test_hit_timing();
    paddr_t a;
    dword_t d, got;
    a = 64'h0880;
    do_load(a, -1, got);
    do_load(a, 0, got);
    check_dword(got, ref_read(a >> 3), "hit load");
    d = rand_bits(64);
    do_store(a + 64'h4, SIZE_WORD, d, 0);
    ref_store(a + 64'h4, SIZE_WORD, d);
    do_load(a, 0, got);
    check_dword(got, ref_read(a >> 3), "load after hit store");
  endtask

  initial begin
    rst         = 1'b1;
    globstall   = 1'b0;
    cpu_wren    = 1'b0;
    cpu_rden    = 1'b0;
    store_src   = SIZE_BYTE;
    amo_op      = '0;
    amo         = 1'b0;
    phys_addr   = '0;
    cpu_data_in = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_stall(cpu_stall, 1'b0, "stall after reset");
    test_reset_load();
    test_store_sizes();
    test_write_back();
    test_amo_ops();
    test_globstall();
    test_hit_timing();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
